// File: logic/xbus_build_id.svh
// Build identifier
`ifndef XBUS_BUILD_ID_SVH
`define XBUS_BUILD_ID_SVH
// Bumped per release of the I/O block
`define BUILD_ID 16'h0104
`endif

// File: logic/xbus_io_pkg.sv
// Extended bus I/O block definitions

package xbus_io_pkg;

   //////////////////////////////////////////////////////////////////////
   // Address windows

   // 64-word I/O window
   parameter logic [21:0] io_window_base    = 22'o17772000;
   // Network sub-window, never decoded here
   parameter logic [21:0] chaos_window_base = 22'o17772060;

   // Register addresses
   parameter logic [21:0] reg_build_id = 22'o17772037;
   parameter logic [21:0] reg_kbd_lo   = 22'o17772040;
   parameter logic [21:0] reg_kbd_hi   = 22'o17772041;
   parameter logic [21:0] reg_mouse_y  = 22'o17772042;
   parameter logic [21:0] reg_mouse_x  = 22'o17772043;
   parameter logic [21:0] reg_csr      = 22'o17772045;
   parameter logic [21:0] reg_us_lo    = 22'o17772050;
   parameter logic [21:0] reg_us_hi    = 22'o17772051;
   parameter logic [21:0] reg_hz60     = 22'o17772052;

   //////////////////////////////////////////////////////////////////////
   // Interrupts and control

   parameter logic [7:0] vec_kbd_mouse = 8'o260;
   parameter logic [7:0] vec_clock     = 8'o274;

   // Interrupt enables in the control field
   parameter int csr_mouse_ie = 1;
   parameter int csr_clock_ie = 3;

   // Pending flag positions
   parameter int rdy_mouse = 0;
   parameter int rdy_kbd   = 1;
   parameter int rdy_clock = 2;

   // Key scan framing
   parameter logic [4:0] key_marker = 5'b11111;
   parameter logic [2:0] key_source = 3'b001;

   // Keyboard scan word, built as fields, read back as halves
   typedef union packed {
      struct packed {
         logic [7:0]  pad;
         logic [4:0]  marker;
         logic [2:0]  source;
         logic [15:0] key;
      } fields;
      struct packed {
         logic [15:0] hi;
         logic [15:0] lo;
      } halves;
   } key_scan_t;

endpackage

// File: logic/xbus_req_if.sv
// Decoded bus access

`timescale 1ns/1ps
`default_nettype none

interface xbus_req_if;

   // Access qualified by the window decode
   logic        sel;
   // High for a write, low for a read
   logic        write;
   // Word address as seen on the bus
   logic [21:0] addr;
   // Write data from the master
   logic [31:0] wdata;

   // Address decoder side
   modport decoder (
      output sel, write, addr, wdata
   );

   // Register file side
   modport regs (
      input sel, write, addr, wdata
   );

endinterface

`default_nettype wire

// File: logic/xbus_io_decode.sv
// I/O window decode and ack

`timescale 1ns/1ps
`default_nettype none

module xbus_io_decode (
   input  logic        clk,
   input  logic        reset,
   input  logic        req,
   input  logic        write,
   input  logic [21:0] addr,
   input  logic [31:0] datain,
   output logic        decode,
   output logic        ack,
   xbus_req_if.decoder bus
);

   logic       in_window;
   logic       in_chaos;
   logic [1:0] ack_pipe;

   //////////////////////////////////////////////////////////////////////
   // Address match

   // Upper 16 bits pick the 64-word window
   assign in_window = addr[21:6] == xbus_io_pkg::io_window_base[21:6];
   // Upper 19 bits pick the 8-word network window
   assign in_chaos  = addr[21:3] == xbus_io_pkg::chaos_window_base[21:3];

   // Combinational, follows req directly
   assign decode = req & in_window & ~in_chaos;

   // Qualified access toward the register file
   assign bus.sel   = decode;
   assign bus.write = write;
   assign bus.addr  = addr;
   assign bus.wdata = datain;

   //////////////////////////////////////////////////////////////////////
   // Ack delay

   // Two-stage shift of decode
   always_ff @(posedge clk) begin
      if (reset) begin
         ack_pipe <= 2'b00;
      end else begin
         ack_pipe[0] <= decode;
         ack_pipe[1] <= ack_pipe[0];
      end
   end

   // Drops two edges after decode drops
   assign ack = ack_pipe[1];

endmodule

`default_nettype wire

// File: logic/io_timers.sv
// Microsecond and 60 Hz timers

`timescale 1ns/1ps
`default_nettype none

module io_timers #(
   parameter int clks_per_us = 50,
   parameter int us_per_hz60 = 16667
) (
   input  logic        clk,
   input  logic        reset,
   input  logic        hz60_enable,
   output logic [31:0] us_count,
   output logic [31:0] hz60_count,
   output logic        hz60_fire
);

   // Divider widths, at least one bit each
   localparam int pre_w = $clog2(clks_per_us + 1);
   localparam int div_w = $clog2(us_per_hz60 + 1);

   logic [pre_w-1:0] pre_count;
   logic [div_w-1:0] div_count;
   logic             us_tick;
   logic             hz60_tick;

   //////////////////////////////////////////////////////////////////////
   // Microsecond prescaler

   // Last clock of each microsecond
   assign us_tick = pre_count == pre_w'(clks_per_us - 1);

   always_ff @(posedge clk) begin
      if (reset) begin
         pre_count <= '0;
         us_count  <= '0;
      end else if (us_tick) begin
         pre_count <= '0;
         us_count  <= us_count + 32'd1;
      end else begin
         pre_count <= pre_count + 1'b1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // 60 Hz divider

   // Last microsecond of each 60 Hz period
   assign hz60_tick = hz60_enable & us_tick & (div_count == div_w'(us_per_hz60 - 1));

   always_ff @(posedge clk) begin
      if (reset) begin
         div_count  <= '0;
         hz60_count <= '0;
         hz60_fire  <= 1'b0;
      end else begin
         // Fire marks the cycle the count moves
         hz60_fire <= hz60_tick;
         if (hz60_tick) begin
            div_count  <= '0;
            hz60_count <= hz60_count + 32'd1;
         end else if (hz60_enable && us_tick) begin
            div_count <= div_count + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/io_input_latch.sv
// Keyboard and mouse capture

`timescale 1ns/1ps
`default_nettype none

module io_input_latch (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  kb_ready,
   input  logic [15:0]           kb_data,
   input  logic                  ms_ready,
   input  logic [11:0]           ms_x,
   input  logic [11:0]           ms_y,
   input  logic [2:0]            ms_button,
   output xbus_io_pkg::key_scan_t key_scan,
   output logic [11:0]           mouse_x,
   output logic [11:0]           mouse_y,
   output logic [2:0]            mouse_buttons
);

   //////////////////////////////////////////////////////////////////////
   // Keyboard

   // Key data framed by marker and source code
   always_ff @(posedge clk) begin
      if (reset) begin
         key_scan <= '0;
      end else if (kb_ready) begin
         key_scan.fields.pad    <= 8'h00;
         key_scan.fields.marker <= xbus_io_pkg::key_marker;
         key_scan.fields.source <= xbus_io_pkg::key_source;
         key_scan.fields.key    <= kb_data;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Mouse

   // Buttons kept as head, middle, tail
   always_ff @(posedge clk) begin
      if (reset) begin
         mouse_x       <= '0;
         mouse_y       <= '0;
         mouse_buttons <= '0;
      end else if (ms_ready) begin
         mouse_x       <= ms_x;
         mouse_y       <= ms_y;
         mouse_buttons <= ms_button;
      end
   end

endmodule

`default_nettype wire

// File: logic/io_regs.sv
// I/O register file and interrupts

`timescale 1ns/1ps
`default_nettype none

`include "xbus_build_id.svh"

module io_regs (
   input  logic                  clk,
   input  logic                  reset,
   xbus_req_if.regs              bus,
   input  xbus_io_pkg::key_scan_t key_scan,
   input  logic [11:0]           mouse_x,
   input  logic [11:0]           mouse_y,
   input  logic [2:0]            mouse_buttons,
   input  logic [31:0]           us_count,
   input  logic [31:0]           hz60_count,
   input  logic                  hz60_fire,
   input  logic                  kb_ready,
   input  logic                  ms_ready,
   output logic [31:0]           dataout,
   output logic                  hz60_enable,
   output logic                  interrupt,
   output logic [7:0]            vector
);

   logic [3:0]  ctrl;
   logic [2:0]  flags;
   logic [2:0]  set_flags;
   logic [2:0]  clr_flags;
   logic        rd_sel;
   logic        wr_sel;
   logic [31:0] rd_word;
   logic        kb_int;
   logic        ms_int;
   logic        clk_int;

   assign rd_sel = bus.sel & ~bus.write;
   assign wr_sel = bus.sel & bus.write;

   //////////////////////////////////////////////////////////////////////
   // Control field and pending flags

   // Strobes set, reads clear
   always_comb begin
      set_flags = '0;
      clr_flags = '0;
      set_flags[xbus_io_pkg::rdy_mouse] = ms_ready;
      set_flags[xbus_io_pkg::rdy_kbd]   = kb_ready;
      set_flags[xbus_io_pkg::rdy_clock] = hz60_fire;
      // Either keyboard half acknowledges
      clr_flags[xbus_io_pkg::rdy_kbd]   = rd_sel &
         ((bus.addr == xbus_io_pkg::reg_kbd_lo) | (bus.addr == xbus_io_pkg::reg_kbd_hi));
      // Only the y word acknowledges the mouse
      clr_flags[xbus_io_pkg::rdy_mouse] = rd_sel & (bus.addr == xbus_io_pkg::reg_mouse_y);
      clr_flags[xbus_io_pkg::rdy_clock] = rd_sel & (bus.addr == xbus_io_pkg::reg_hz60);
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ctrl        <= 4'h0;
         flags       <= 3'b000;
         hz60_enable <= 1'b0;
      end else begin
         if (wr_sel && bus.addr == xbus_io_pkg::reg_csr) begin
            ctrl <= bus.wdata[3:0];
         end
         // Set wins over a same-cycle clear, even mid-access
         flags <= set_flags | (flags & ~clr_flags);
         // First 60 Hz read starts the tick counter for good
         if (clr_flags[xbus_io_pkg::rdy_clock]) begin
            hz60_enable <= 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Read mux

   always_comb begin
      rd_word = 32'h0;
      case (bus.addr)
         xbus_io_pkg::reg_build_id: rd_word = {16'h0, `BUILD_ID};
         xbus_io_pkg::reg_kbd_lo:   rd_word = {16'h0, key_scan.halves.lo};
         xbus_io_pkg::reg_kbd_hi:   rd_word = {16'h0, key_scan.halves.hi};
         // Head, middle, tail above y
         xbus_io_pkg::reg_mouse_y:  rd_word = {17'h0, mouse_buttons, mouse_y};
         // Raw quadrature bits not wired, read as zero
         xbus_io_pkg::reg_mouse_x:  rd_word = {16'h0, 4'h0, mouse_x};
         xbus_io_pkg::reg_csr:      rd_word = {25'h0, flags, ctrl};
         xbus_io_pkg::reg_us_lo:    rd_word = {16'h0, us_count[15:0]};
         xbus_io_pkg::reg_us_hi:    rd_word = {16'h0, us_count[31:16]};
         xbus_io_pkg::reg_hz60:     rd_word = hz60_count;
         default:                   rd_word = 32'h0;
      endcase
   end

   // Zero outside reads
   always_ff @(posedge clk) begin
      if (reset) begin
         dataout <= 32'h0;
      end else if (rd_sel) begin
         dataout <= rd_word;
      end else begin
         dataout <= 32'h0;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Interrupt and vector

   // Keyboard has no mask
   assign kb_int  = flags[xbus_io_pkg::rdy_kbd];
   assign ms_int  = flags[xbus_io_pkg::rdy_mouse] & ctrl[xbus_io_pkg::csr_mouse_ie];
   assign clk_int = flags[xbus_io_pkg::rdy_clock] & ctrl[xbus_io_pkg::csr_clock_ie];

   assign interrupt = kb_int | ms_int | clk_int;

   // Keyboard and mouse share a vector, ahead of the clock
   assign vector = (kb_int | ms_int) ? xbus_io_pkg::vec_kbd_mouse :
                   clk_int           ? xbus_io_pkg::vec_clock     :
                                       8'h00;

endmodule

`default_nettype wire

// File: logic/xbus_io.sv
// Extended bus I/O block

`timescale 1ns/1ps
`default_nettype none

module xbus_io #(
   parameter int clks_per_us = 50,
   parameter int us_per_hz60 = 16667
) (
   input  logic        clk,
   input  logic        reset,
   input  logic [21:0] addr,
   input  logic [31:0] datain,
   input  logic        req,
   input  logic        write,
   input  logic        ms_ready,
   input  logic [11:0] ms_x,
   input  logic [11:0] ms_y,
   input  logic [2:0]  ms_button,
   input  logic        kb_ready,
   input  logic [15:0] kb_data,
   output logic [31:0] dataout,
   output logic        ack,
   output logic        decode,
   output logic        interrupt,
   output logic [7:0]  vector
);

   // Captured device words
   xbus_io_pkg::key_scan_t key_scan;
   logic [11:0]            mouse_x;
   logic [11:0]            mouse_y;
   logic [2:0]             mouse_buttons;

   // Timer state
   logic [31:0] us_count;
   logic [31:0] hz60_count;
   logic        hz60_fire;
   logic        hz60_enable;

   //////////////////////////////////////////////////////////////////////
   // Input side

   xbus_req_if u_req ();

   xbus_io_decode u_decode (
      .clk    (clk),
      .reset  (reset),
      .req    (req),
      .write  (write),
      .addr   (addr),
      .datain (datain),
      .decode (decode),
      .ack    (ack),
      .bus    (u_req.decoder)
   );

   io_timers #(
      .clks_per_us (clks_per_us),
      .us_per_hz60 (us_per_hz60)
   ) u_timers (
      .clk         (clk),
      .reset       (reset),
      .hz60_enable (hz60_enable),
      .us_count    (us_count),
      .hz60_count  (hz60_count),
      .hz60_fire   (hz60_fire)
   );

   io_input_latch u_latch (
      .clk           (clk),
      .reset         (reset),
      .kb_ready      (kb_ready),
      .kb_data       (kb_data),
      .ms_ready      (ms_ready),
      .ms_x          (ms_x),
      .ms_y          (ms_y),
      .ms_button     (ms_button),
      .key_scan      (key_scan),
      .mouse_x       (mouse_x),
      .mouse_y       (mouse_y),
      .mouse_buttons (mouse_buttons)
   );

   //////////////////////////////////////////////////////////////////////
   // Registers, flags and interrupt output

   io_regs u_regs (
      .clk           (clk),
      .reset         (reset),
      .bus           (u_req.regs),
      .key_scan      (key_scan),
      .mouse_x       (mouse_x),
      .mouse_y       (mouse_y),
      .mouse_buttons (mouse_buttons),
      .us_count      (us_count),
      .hz60_count    (hz60_count),
      .hz60_fire     (hz60_fire),
      .kb_ready      (kb_ready),
      .ms_ready      (ms_ready),
      .dataout       (dataout),
      .hz60_enable   (hz60_enable),
      .interrupt     (interrupt),
      .vector        (vector)
   );

endmodule

`default_nettype wire

// File: verification/xbus_io_sva.sv
// Decode and ack assertions

`timescale 1ns/1ps

module xbus_io_sva (
   input logic        clk,
   input logic        reset,
   input logic [21:0] addr,
   input logic        decode,
   input logic        ack
);

   logic in_net;

   // Eight words up from the network base
   assign in_net = addr >= xbus_io_pkg::chaos_window_base &&
                   addr <= xbus_io_pkg::chaos_window_base + 22'd7;

   // Ack is decode seen two edges late
   ack_follows_decode: assert property (
      @(posedge clk) disable iff (reset) ack == $past(decode, 2)
   ) else $error("ack is not decode delayed by two cycles");

   // Network sub-window never answers here
   no_chaos_decode: assert property (
      @(posedge clk) !(decode && in_net)
   ) else $error("decode raised inside the network sub-window");

   // Sync reset clears the ack shift
   ack_low_in_reset: assert property (
      @(posedge clk) reset |=> !ack
   ) else $error("ack high during reset");

endmodule

//////////////////////////////////////////////////////////////////////
// Attach to every decoder instance

bind xbus_io_decode xbus_io_sva u_sva (
   .clk    (clk),
   .reset  (reset),
   .addr   (addr),
   .decode (decode),
   .ack    (ack)
);

// File: verification/xbus_io_tb.sv
// Extended bus I/O block testbench

`timescale 1ns/1ps

module xbus_io_tb;

   localparam int clks_per_us = 4;
   localparam int us_per_hz60 = 5;

   // Rough length of each test in cycles
   localparam int len_reset  = 20;
   localparam int len_decode = 60;
   localparam int len_ctrl   = 60;
   localparam int len_kbd    = 60;
   localparam int len_mouse  = 100;
   localparam int len_mix    = 60 * 8;
   localparam int len_timers = 200;
   localparam int cycle_limit =
      3 * (len_reset + len_decode + len_ctrl + len_kbd + len_mouse + len_mix + len_timers);

   logic        clk;
   logic        reset;
   logic [21:0] addr;
   logic [31:0] datain;
   logic        req;
   logic        write;
   logic        ms_ready;
   logic [11:0] ms_x;
   logic [11:0] ms_y;
   logic [2:0]  ms_button;
   logic        kb_ready;
   logic [15:0] kb_data;
   logic [31:0] dataout;
   logic        ack;
   logic        decode;
   logic        interrupt;
   logic [7:0]  vector;

   //////////////////////////////////////////////////////////////////////
   // Shadow of the block, advanced at each rising edge

   logic [3:0]  sh_ctrl;
   logic [2:0]  sh_flags;
   logic [15:0] sh_kb;
   logic [15:0] sh_kb_hi;
   logic [11:0] sh_mx;
   logic [11:0] sh_my;
   logic [2:0]  sh_mb;
   logic        sh_en;
   logic        sh_fire;
   int          sh_pre;
   int          sh_div;
   logic [31:0] sh_us;
   logic [31:0] sh_hz;
   logic [31:0] sh_data;
   logic [1:0]  sh_ack;

   int errors;
   int checks;
   int cycles;

   xbus_io #(
      .clks_per_us (clks_per_us),
      .us_per_hz60 (us_per_hz60)
   ) u_dut (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .datain    (datain),
      .req       (req),
      .write     (write),
      .ms_ready  (ms_ready),
      .ms_x      (ms_x),
      .ms_y      (ms_y),
      .ms_button (ms_button),
      .kb_ready  (kb_ready),
      .kb_data   (kb_data),
      .dataout   (dataout),
      .ack       (ack),
      .decode    (decode),
      .interrupt (interrupt),
      .vector    (vector)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // 64-word window minus the 8-word network window
   function automatic logic exp_decode(input logic r, input logic [21:0] a);
      logic in_io;
      logic in_net;
      in_io  = a >= xbus_io_pkg::io_window_base &&
               a <= xbus_io_pkg::io_window_base + 22'd63;
      in_net = a >= xbus_io_pkg::chaos_window_base &&
               a <= xbus_io_pkg::chaos_window_base + 22'd7;
      return r && in_io && !in_net;
   endfunction

   // Expected read word from the shadow
   function automatic logic [31:0] ref_word(input logic [21:0] a);
      case (a)
         xbus_io_pkg::reg_build_id: return {16'h0, `BUILD_ID};
         xbus_io_pkg::reg_kbd_hi:   return {16'h0, sh_kb_hi};
         xbus_io_pkg::reg_kbd_lo:   return {16'h0, sh_kb};
         xbus_io_pkg::reg_mouse_y:  return {17'h0, sh_mb, sh_my};
         xbus_io_pkg::reg_mouse_x:  return {20'h0, sh_mx};
         xbus_io_pkg::reg_csr:      return {25'h0, sh_flags, sh_ctrl};
         xbus_io_pkg::reg_us_lo:    return {16'h0, sh_us[15:0]};
         xbus_io_pkg::reg_us_hi:    return {16'h0, sh_us[31:16]};
         xbus_io_pkg::reg_hz60:     return sh_hz;
         default:                   return 32'h0;
      endcase
   endfunction

   // Interrupt in bit 8, vector below
   function automatic logic [8:0] ref_irq();
      logic kb;
      logic ms;
      logic ck;
      kb = sh_flags[xbus_io_pkg::rdy_kbd];
      ms = sh_flags[xbus_io_pkg::rdy_mouse] & sh_ctrl[xbus_io_pkg::csr_mouse_ie];
      ck = sh_flags[xbus_io_pkg::rdy_clock] & sh_ctrl[xbus_io_pkg::csr_clock_ie];
      if (kb || ms) return {1'b1, 8'o260};
      if (ck) return {1'b1, 8'o274};
      return 9'h0;
   endfunction

   always @(posedge clk) begin : shadow_model
      logic       rd;
      logic       us_tick;
      logic       hz_tick;
      logic [2:0] set;
      logic [2:0] clr;
      if (reset) begin
         sh_ctrl  <= '0;
         sh_flags <= '0;
         sh_kb    <= '0;
         sh_kb_hi <= '0;
         sh_mx    <= '0;
         sh_my    <= '0;
         sh_mb    <= '0;
         sh_en    <= 1'b0;
         sh_fire  <= 1'b0;
         sh_pre   <= 0;
         sh_div   <= 0;
         sh_us    <= '0;
         sh_hz    <= '0;
         sh_data  <= '0;
         sh_ack   <= '0;
      end else begin
         rd      = exp_decode(req, addr) && !write;
         us_tick = sh_pre == clks_per_us - 1;
         hz_tick = sh_en && us_tick && sh_div == us_per_hz60 - 1;
         set = {sh_fire, kb_ready, ms_ready};
         clr = 3'b000;
         clr[xbus_io_pkg::rdy_kbd]   = rd && (addr == xbus_io_pkg::reg_kbd_lo ||
            addr == xbus_io_pkg::reg_kbd_hi);
         clr[xbus_io_pkg::rdy_mouse] = rd && addr == xbus_io_pkg::reg_mouse_y;
         clr[xbus_io_pkg::rdy_clock] = rd && addr == xbus_io_pkg::reg_hz60;
         // Strobe beats a read in the same cycle
         sh_flags <= set | (sh_flags & ~clr);
         if (clr[xbus_io_pkg::rdy_clock]) sh_en <= 1'b1;
         if (exp_decode(req, addr) && write && addr == xbus_io_pkg::reg_csr) begin
            sh_ctrl <= datain[3:0];
         end
         if (kb_ready) begin
            // Pad, marker 11111, source 001
            sh_kb_hi <= {8'h00, 5'b11111, 3'b001};
            sh_kb    <= kb_data;
         end
         if (ms_ready) begin
            sh_mx <= ms_x;
            sh_my <= ms_y;
            sh_mb <= ms_button;
         end
         sh_data <= rd ? ref_word(addr) : 32'h0;
         sh_ack  <= {sh_ack[0], exp_decode(req, addr)};
         // Timers
         sh_fire <= hz_tick;
         sh_pre  <= us_tick ? 0 : sh_pre + 1;
         if (us_tick) sh_us <= sh_us + 1;
         if (hz_tick) begin
            sh_div <= 0;
            sh_hz  <= sh_hz + 1;
         end else if (sh_en && us_tick) begin
            sh_div <= sh_div + 1;
         end
      end
   end

   // Every cycle against the shadow, before the edge moves anything
   always @(posedge clk) begin
      if (!reset) begin
         check("dataout", dataout, sh_data);
         check("decode", decode, exp_decode(req, addr));
         check("ack", ack, sh_ack[1]);
         check("interrupt", interrupt, ref_irq() >> 8);
         check("vector", vector, ref_irq() & 9'h0ff);
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         $display("timeout: run exceeded %0d cycles", cycle_limit);
         $display("checks %0d, errors %0d", checks, errors);
         $display("=== FAIL ===");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Bus and device stimulus

   task automatic wait_ack(input logic [21:0] a);
      int waited;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!ack && waited < 16);
      if (!ack) begin
         errors++;
         $display("no ack for access to %o at %0t", a, $time);
      end else begin
         check("ack_delay", waited, 2);
      end
   endtask

   task automatic bus_read(input logic [21:0] a, output logic [31:0] d);
      @(negedge clk);
      req   = 1'b1;
      write = 1'b0;
      addr  = a;
      wait_ack(a);
      d   = dataout;
      req = 1'b0;
      // Let ack fall before the next request
      repeat (2) @(negedge clk);
   endtask

   task automatic bus_write(input logic [21:0] a, input logic [31:0] d);
      @(negedge clk);
      req    = 1'b1;
      write  = 1'b1;
      addr   = a;
      datain = d;
      wait_ack(a);
      req   = 1'b0;
      write = 1'b0;
      repeat (2) @(negedge clk);
   endtask

   task automatic probe_no_decode(input logic [21:0] a);
      @(negedge clk);
      req   = 1'b1;
      write = 1'b0;
      addr  = a;
      repeat (4) @(negedge clk);
      check("decode", decode, 1'b0);
      check("ack", ack, 1'b0);
      req = 1'b0;
   endtask

   task automatic pulse_key(input logic [15:0] k);
      @(negedge clk);
      kb_data  = k;
      kb_ready = 1'b1;
      @(negedge clk);
      kb_ready = 1'b0;
   endtask

   task automatic pulse_mouse(input logic [11:0] x, input logic [11:0] y, input logic [2:0] b);
      @(negedge clk);
      ms_x      = x;
      ms_y      = y;
      ms_button = b;
      ms_ready  = 1'b1;
      @(negedge clk);
      ms_ready = 1'b0;
   endtask

   // Mapped and unmapped words inside the window
   function automatic logic [21:0] pick_addr(input int unsigned r);
      case (r % 11)
         0: return xbus_io_pkg::reg_build_id;
         1: return xbus_io_pkg::reg_kbd_lo;
         2: return xbus_io_pkg::reg_kbd_hi;
         3: return xbus_io_pkg::reg_mouse_y;
         4: return xbus_io_pkg::reg_mouse_x;
         5: return xbus_io_pkg::reg_csr;
         6: return xbus_io_pkg::reg_us_lo;
         7: return xbus_io_pkg::reg_us_hi;
         8: return 22'o17772000;
         9: return 22'o17772046;
         default: return 22'o17772077;
      endcase
   endfunction

   initial begin
      logic [31:0] d;
      logic [31:0] a0;
      int          c0;
      int          n;
      int          delta;
      void'($urandom(54));
      errors = 0;
      checks = 0;
      cycles = 0;
      reset = 1'b1;
      req = 1'b0;
      write = 1'b0;
      addr = '0;
      datain = '0;
      ms_ready = 1'b0;
      ms_x = '0;
      ms_y = '0;
      ms_button = '0;
      kb_ready = 1'b0;
      kb_data = '0;
      repeat (16) @(negedge clk);
      reset = 1'b0;

      // Decode window and its holes
      probe_no_decode(22'o17772060);
      probe_no_decode(22'o17772067);
      probe_no_decode(22'o17771777);
      probe_no_decode(22'o17773000);
      bus_read(22'o17772070, d);

      // Control field, build ID, unmapped words
      bus_write(xbus_io_pkg::reg_csr, 32'hffff_fff5);
      bus_read(xbus_io_pkg::reg_csr, d);
      check("csr_field", d[3:0], 4'h5);
      check("csr_upper", d[31:7], 0);
      bus_read(xbus_io_pkg::reg_build_id, d);
      check("build_id", d, {16'h0, `BUILD_ID});
      bus_read(22'o17772046, d);
      check("unmapped", d, 0);
      bus_write(xbus_io_pkg::reg_csr, 32'h0);

      // Keyboard, never masked
      pulse_key(16'ha5c3);
      check("interrupt", interrupt, 1'b1);
      check("vector", vector, 8'o260);
      bus_read(xbus_io_pkg::reg_kbd_hi, d);
      check("kbd_hi", d, 32'h0000_00f9);
      check("interrupt", interrupt, 1'b0);
      bus_read(xbus_io_pkg::reg_kbd_lo, d);
      check("kbd_lo", d, 32'h0000_a5c3);

      // Mouse masked until its enable is set
      pulse_mouse(12'h123, 12'h456, 3'b101);
      check("interrupt", interrupt, 1'b0);
      bus_write(xbus_io_pkg::reg_csr, 32'h2);
      check("interrupt", interrupt, 1'b1);
      check("vector", vector, 8'o260);
      bus_read(xbus_io_pkg::reg_mouse_y, d);
      check("mouse_y", d, 32'h0000_5456);
      check("interrupt", interrupt, 1'b0);
      bus_read(xbus_io_pkg::reg_mouse_x, d);
      check("mouse_x", d, 32'h0000_0123);
      // Strobe lands on the last edge of a y read
      fork
         bus_read(xbus_io_pkg::reg_mouse_y, d);
         begin
            repeat (2) @(negedge clk);
            ms_ready = 1'b1;
            @(negedge clk);
            ms_ready = 1'b0;
         end
      join
      bus_read(xbus_io_pkg::reg_csr, d);
      check("mouse_pending", d[4], 1'b1);
      bus_read(xbus_io_pkg::reg_mouse_y, d);
      bus_write(xbus_io_pkg::reg_csr, 32'h0);

      // Random mix, shadow compares every cycle
      repeat (60) begin
         case ($urandom % 4)
            0: bus_read(pick_addr($urandom), d);
            1: bus_write(($urandom % 2) ? xbus_io_pkg::reg_csr : pick_addr($urandom), $urandom);
            2: pulse_key($urandom);
            default: pulse_mouse($urandom, $urandom, $urandom);
         endcase
      end
      bus_read(xbus_io_pkg::reg_kbd_lo, d);
      bus_read(xbus_io_pkg::reg_mouse_y, d);

      // Microsecond rate
      bus_read(xbus_io_pkg::reg_us_lo, a0);
      c0 = cycles;
      repeat (40) @(negedge clk);
      bus_read(xbus_io_pkg::reg_us_lo, d);
      n = cycles - c0;
      delta = int'(d[15:0] - a0[15:0]);
      if (delta < n / 4 - 1 || delta > n / 4 + 1) check("us_delta", delta, n / 4);

      // 60 Hz clock interrupt, then keyboard on top
      bus_write(xbus_io_pkg::reg_csr, 32'h8);
      bus_read(xbus_io_pkg::reg_hz60, d);
      n = 0;
      while (!interrupt && n < 60) begin
         @(negedge clk);
         n++;
      end
      if (!interrupt) begin
         errors++;
         $display("clock interrupt never raised at %0t", $time);
      end else begin
         check("vector", vector, 8'o274);
      end
      pulse_key(16'h0042);
      check("vector", vector, 8'o260);
      bus_read(xbus_io_pkg::reg_kbd_lo, d);
      bus_read(xbus_io_pkg::reg_hz60, d);

      repeat (4) @(negedge clk);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// File: sim.f
+incdir+logic
logic/xbus_io_pkg.sv
logic/xbus_req_if.sv
logic/xbus_io_decode.sv
logic/io_timers.sv
logic/io_input_latch.sv
logic/io_regs.sv
logic/xbus_io.sv
verification/xbus_io_sva.sv
verification/xbus_io_tb.sv
